/* common/fb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer display package: 640x480 geometry, 160x120 framebuffer,
// 16-colour palette widths and the position / SDL pixel structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package fb_pkg;

    // display geometry, signed so blanking sits at negative coords
    localparam int CORDW = 16;     // coordinate width
    localparam int H_STA = -160;   // horizontal start incl. blanking
    localparam int H_END = 639;    // last active column
    localparam int V_STA = -45;    // vertical start incl. blanking
    localparam int V_END = 479;    // last active line

    // framebuffer
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);     // 15 bits

    // colour
    localparam int CHANW = 4;          // bits per channel
    localparam int COLRW = 3 * CHANW;  // 12-bit rgb
    localparam int CIDXW = 4;          // 16 palette entries

    // address flag -> bram -> clut
    localparam int READ_LAT = 3;

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [FB_ADDRW-1:0]     fb_addr_t;
    typedef logic [CIDXW-1:0]        cidx_t;
    typedef logic [COLRW-1:0]        colr_t;
    typedef logic [2*CHANW-1:0]      chan8_t;  // widened output channel

    localparam colr_t BG_COLR = 12'h137;  // outside the framebuffer area

    // beam position, 34 bits
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   de;     // active area
        logic   frame;  // first cycle of frame
    } disp_pos_t;

    // sdl style output pixel, 58 bits
    typedef struct packed {
        disp_pos_t pos;
        chan8_t    r;
        chan8_t    g;
        chan8_t    b;
    } sdl_pix_t;

endpackage

`default_nettype wire

/* src/display_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 display timing: signed beam position, data enable and
// start-of-frame pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module display_timing import fb_pkg::*; (
    input  wire logic clk_pix,   // pixel clock
    input  wire logic reset,     // sync, active high
    output disp_pos_t pos        // position, de, frame
);

    coord_t sx;  // horizontal counter
    coord_t sy;  // vertical counter

    // one pixel per cycle, line wrap advances sy
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= coord_t'(H_STA);
            sy <= coord_t'(V_STA);
        end else begin
            if (sx == H_END) begin  // end of line
                sx <= coord_t'(H_STA);
                if (sy == V_END) begin  // end of screen
                    sy <= coord_t'(V_STA);
                end else begin
                    sy <= sy + coord_t'(1);
                end
            end else begin
                sx <= sx + coord_t'(1);
            end
        end
    end

    // flags straight from the counters
    always_comb begin
        pos.sx    = sx;
        pos.sy    = sy;
        pos.de    = (sx >= 0 && sy >= 0);              // active area only
        pos.frame = (sx == H_STA && sy == V_STA);      // top-left of blanking
    end

    // counter never leaves the line range, wrap must catch H_END
    a_sx_range: assert property (@(posedge clk_pix) disable iff (reset)
        (sx >= H_STA && sx <= H_END))
        else $error("display_timing: sx out of range %0d", sx);

endmodule

`default_nettype wire

/* framebuffer/fb_bram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer block RAM, 19200 x 4-bit colour index, simple dual port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fb_bram import fb_pkg::*; (
    input  wire logic     clk_pix,     // single clock for both ports
    input  wire logic     we,          // write strobe
    input  wire fb_addr_t addr_write,
    input  wire cidx_t    data_in,
    input  wire fb_addr_t addr_read,
    output cidx_t         data_out     // valid one cycle after addr_read
);

    cidx_t mem [FB_PIXELS];  // one index per pixel

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // registered read, infers block ram
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

endmodule

`default_nettype wire

/* framebuffer/fb_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer reader: look-ahead read address for the 160x120 area,
// runs READ_LAT cycles ahead of the beam, owns the framebuffer RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fb_reader import fb_pkg::*; (
    input  wire logic      clk_pix,   // pixel clock
    input  wire logic      reset,     // sync, active high
    input  wire disp_pos_t pos,       // beam position from timing
    input  wire logic      we,        // framebuffer write strobe
    input  wire fb_addr_t  waddr,
    input  wire cidx_t     wdata,
    output cidx_t          cidx       // index, two cycles after the flag
);

    logic     read_fb;    // address is live for a visible fb pixel
    fb_addr_t addr_read;  // next pixel to fetch
    logic     in_window;  // combinational look-ahead window

    // window shifted left by READ_LAT
    // flag reg +1, bram +1, clut +1 lands on sx == 0
    always_comb begin
        in_window = (pos.sy >= 0 && pos.sy < FB_HEIGHT
                     && pos.sx >= -READ_LAT && pos.sx < FB_WIDTH - READ_LAT);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            read_fb   <= 1'b0;
            addr_read <= '0;
        end else begin
            read_fb <= in_window;
            if (pos.frame) begin  // restart at top of image
                addr_read <= '0;
            end else if (read_fb) begin  // step once per fb pixel
                addr_read <= addr_read + fb_addr_t'(1);
            end
        end
    end

    fb_bram fb_bram_inst (
        .clk_pix,
        .we,
        .addr_write (waddr),
        .data_in    (wdata),
        .addr_read,
        .data_out   (cidx)
    );

    // 120 rows of 160 never run past the buffer
    a_addr_bound: assert property (@(posedge clk_pix) disable iff (reset)
        read_fb |-> (addr_read < FB_PIXELS))
        else $error("fb_reader: read address %0d past framebuffer", addr_read);

    // each frame ends with the address exactly at the buffer end
    a_addr_full: assert property (@(posedge clk_pix) disable iff (reset)
        (pos.frame && $past(!reset) && $past(pos.sx) == H_END && $past(pos.sy) == V_END)
        |-> (addr_read == fb_addr_t'(FB_PIXELS)))
        else $error("fb_reader: frame ended at address %0d", addr_read);

endmodule

`default_nettype wire

/* src/clut.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour lookup table, 16 x 12-bit rgb with registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module clut import fb_pkg::*; (
    input  wire logic  clk_pix,   // pixel clock
    input  wire logic  we,        // palette write strobe
    input  wire cidx_t widx,      // entry to write
    input  wire colr_t wcolr,     // new rgb
    input  wire cidx_t cidx,      // lookup index from framebuffer
    output colr_t      colr       // rgb, one cycle later
);

    colr_t pal [2**CIDXW];                // palette storage
    logic [2**CIDXW-1:0] written = '0;    // entries loaded so far

    always_ff @(posedge clk_pix) begin
        if (we) begin
            pal[widx] <= wcolr;
        end
        colr <= pal[cidx];  // read old value on same-entry write
    end

    // track which entries have been written
    always_ff @(posedge clk_pix) begin
        if (we) begin
            written <= written | ((2**CIDXW)'(1) << widx);
        end
    end

    // full palette and a clean index give a clean colour next cycle
    a_colr_known: assert property (@(posedge clk_pix)
        (&written && !$isunknown(cidx)) |=> !$isunknown(colr))
        else $error("clut: unknown colour from loaded palette");

endmodule

`default_nettype wire

/* src/pixel_out.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output stage: paints framebuffer, background or black, widens to
// 8-bit channels and registers the SDL pixel stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module pixel_out import fb_pkg::*; (
    input  wire logic      clk_pix,   // pixel clock
    input  wire logic      reset,     // sync, active high
    input  wire disp_pos_t pos,       // current beam position
    input  wire colr_t     colr,      // palette colour for pos
    output sdl_pix_t       sdl        // registered pixel stream
);

    logic  paint_area;  // inside the 160x120 image
    colr_t paint;       // colour before blanking
    colr_t disp;        // final 12-bit colour

    always_comb begin
        paint_area = (pos.sy >= 0 && pos.sy < FB_HEIGHT
                      && pos.sx >= 0 && pos.sx < FB_WIDTH);
        paint = paint_area ? colr : BG_COLR;
        disp  = pos.de ? paint : '0;  // black in blanking
    end

    // 4 -> 8 bits by repeating the nibble
    always_ff @(posedge clk_pix) begin
        sdl.pos.sx <= pos.sx;
        sdl.pos.sy <= pos.sy;
        if (reset) begin
            sdl.pos.de    <= 1'b0;
            sdl.pos.frame <= 1'b0;
            sdl.r         <= '0;
            sdl.g         <= '0;
            sdl.b         <= '0;
        end else begin
            sdl.pos.de    <= pos.de;
            sdl.pos.frame <= pos.frame;
            sdl.r <= {2{disp[3*CHANW-1 -: CHANW]}};
            sdl.g <= {2{disp[2*CHANW-1 -: CHANW]}};
            sdl.b <= {2{disp[CHANW-1 -: CHANW]}};
        end
    end

endmodule

`default_nettype wire

/* src/fb_display_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-colour framebuffer display top: timing, framebuffer reader,
// palette and output stage, with write ports for RAM and palette
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fb_display_top import fb_pkg::*; (
    input  wire logic     clk_pix,      // pixel clock
    input  wire logic     reset,        // sync, active high
    input  wire logic     fb_we,        // framebuffer write strobe
    input  wire fb_addr_t fb_waddr,     // pixel address, row major
    input  wire cidx_t    fb_wdata,     // colour index
    input  wire logic     clut_we,      // palette write strobe
    input  wire cidx_t    clut_widx,    // palette entry
    input  wire colr_t    clut_wcolr,   // 12-bit rgb
    output sdl_pix_t      sdl           // pixel stream out
);

    disp_pos_t pos;       // beam position, de, frame
    cidx_t     fb_cidx;   // index from the framebuffer
    colr_t     fb_colr;   // looked-up rgb, aligned with pos

    // beam
    display_timing display_timing_inst (
        .clk_pix,
        .reset,
        .pos
    );

    // look-ahead fetch
    fb_reader fb_reader_inst (
        .clk_pix,
        .reset,
        .pos,
        .we    (fb_we),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .cidx  (fb_cidx)
    );

    // palette, last cycle of READ_LAT
    clut clut_inst (
        .clk_pix,
        .we    (clut_we),
        .widx  (clut_widx),
        .wcolr (clut_wcolr),
        .cidx  (fb_cidx),
        .colr  (fb_colr)
    );

    pixel_out pixel_out_inst (
        .clk_pix,
        .reset,
        .pos,
        .colr (fb_colr),
        .sdl
    );

endmodule

`default_nettype wire

/* dv/fb_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer display checker: reference pixels, reset state, frame
// geometry and per-test error counts for the SDL pixel stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fb_checker import fb_pkg::*; (
    input  wire logic     clk_pix,                  // pixel clock
    input  wire logic     reset,                    // same reset as the DUT
    input  wire logic     check_en,                 // compare pixels this cycle
    input  wire sdl_pix_t sdl,                      // DUT output stream
    input  wire cidx_t    fb_mirror [FB_PIXELS],    // framebuffer as written
    input  wire colr_t    pal_mirror [16],          // palette as written
    output int            tests_run,
    output int            tests_failed,
    output int            total_errors
);

    localparam int FRAME_CYCLES  = 800 * 525;  // 640+160 by 480+45
    localparam int ACTIVE_PIXELS = 640 * 480;

    string       test_name    = "none";
    int          mon_errors   = 0;      // raised by the monitor process
    int          seq_errors   = 0;      // raised by the task checks
    int          checked      = 0;      // pixels compared so far
    int          err_base     = 0;      // error total at test start
    int          checked_base = 0;
    int          run_count    = 0;
    int          fail_count   = 0;
    int          error_total  = 0;
    logic        reset_q      = 1'b0;   // reset seen at the last edge
    int          since_reset  = 100;    // edges since reset dropped
    int          cyc_count    = 0;      // cycles in the current frame
    int          de_count     = 0;
    int          last_cycles  = 0;      // totals of the last full frame
    int          last_de      = 0;
    int          frames_seen  = 0;
    int          exp_sx       = 0;      // position the stream should show
    int          exp_sy       = 0;
    logic        exp_de;
    logic        pos_sync     = 1'b0;   // beam model locked to the stream
    logic [23:0] exp_rgb;

    assign tests_run    = run_count;
    assign tests_failed = fail_count;
    assign total_errors = error_total;

    // paint rule: palette in the 160x120 corner, background elsewhere, black in blanking
    function automatic logic [23:0] expected_pixel(input coord_t sx, input coord_t sy,
                                                   input logic de);
        colr_t c;
        int    addr;
        if (!de) begin
            c = 12'h000;
        end else if (sx >= 0 && sy >= 0 && sx < FB_WIDTH && sy < FB_HEIGHT) begin
            addr = int'(sy) * FB_WIDTH + int'(sx);  // row major
            c    = pal_mirror[fb_mirror[addr]];
        end else begin
            c = 12'h137;  // background
        end
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};  // nibble repeat
    endfunction

    always @(posedge clk_pix) begin
        // output registered under reset must be cleared
        if (reset_q && (sdl.pos.de !== 1'b0 || sdl.pos.frame !== 1'b0
                        || {sdl.r, sdl.g, sdl.b} !== 24'h0)) begin
            mon_errors++;
            $display("error: %s output not cleared by reset", test_name);
        end
        if (!reset && since_reset == 1 && !sdl.pos.frame) begin
            mon_errors++;
            $display("error: %s no frame pulse right after reset", test_name);
        end
        if (!reset && sdl.pos.frame && (sdl.pos.sx != -160 || sdl.pos.sy != -45)) begin
            mon_errors++;
            $display("error: %s frame pulse at %0d,%0d instead of -160,-45",
                     test_name, sdl.pos.sx, sdl.pos.sy);
        end
        // beam model starts at the first output frame pulse
        if (!pos_sync && !reset && sdl.pos.frame === 1'b1) begin
            pos_sync = 1'b1;
            exp_sx   = -160;
            exp_sy   = -45;
        end
        exp_de = (exp_sx >= 0 && exp_sy >= 0);  // active when both coords non-negative
        if (check_en && !reset) begin
            if (!pos_sync) begin
                mon_errors++;
                $display("error: %s pixel check started before any frame pulse", test_name);
            end else if (sdl.pos.sx !== coord_t'(exp_sx) || sdl.pos.sy !== coord_t'(exp_sy)
                         || sdl.pos.de !== exp_de) begin
                if (mon_errors < 20) begin
                    $display("mismatch %s position expected %0d,%0d de %0b actual %0d,%0d de %0b",
                             test_name, exp_sx, exp_sy, exp_de,
                             sdl.pos.sx, sdl.pos.sy, sdl.pos.de);
                end
                mon_errors++;
            end
            exp_rgb = expected_pixel(coord_t'(exp_sx), coord_t'(exp_sy), exp_de);
            checked++;
            if ({sdl.r, sdl.g, sdl.b} !== exp_rgb) begin
                if (mon_errors < 20) begin  // keep the log short
                    $display("mismatch %s sx=%0d sy=%0d expected %06h actual %06h", test_name,
                             exp_sx, exp_sy, exp_rgb, {sdl.r, sdl.g, sdl.b});
                end
                mon_errors++;
            end
        end
        // step the model one pixel, lines of 800 and frames of 525
        if (pos_sync) begin
            if (exp_sx == 639) begin
                exp_sx = -160;
                exp_sy = (exp_sy == 479) ? -45 : exp_sy + 1;
            end else begin
                exp_sx++;
            end
        end
        // frame length and active count, pulse to pulse
        if (sdl.pos.frame === 1'b1) begin
            last_cycles = cyc_count;
            last_de     = de_count;
            cyc_count   = 1;
            de_count    = 0;
            frames_seen++;
        end else begin
            cyc_count++;
            if (sdl.pos.de === 1'b1) de_count++;
        end
        since_reset = reset ? 0 : since_reset + 1;
        reset_q     = reset;
    end

    task automatic begin_test(input string name);
        test_name    = name;
        err_base     = mon_errors + seq_errors;
        checked_base = checked;
    endtask

    task automatic check_geometry();
        if (frames_seen < 2) begin
            seq_errors++;
            $display("error: %s fewer than two frame pulses seen", test_name);
        end else begin
            if (last_cycles != FRAME_CYCLES) begin
                seq_errors++;
                $display("mismatch %s frame cycles expected %0d actual %0d",
                         test_name, FRAME_CYCLES, last_cycles);
            end
            if (last_de != ACTIVE_PIXELS) begin
                seq_errors++;
                $display("mismatch %s de cycles expected %0d actual %0d",
                         test_name, ACTIVE_PIXELS, last_de);
            end
        end
    endtask

    task automatic end_test(input logic full_frame);
        int errs;
        int pix;
        pix = checked - checked_base;
        if (full_frame && pix != FRAME_CYCLES) begin
            seq_errors++;
            $display("error: %s compared %0d pixels, not one full frame", test_name, pix);
        end
        errs = mon_errors + seq_errors - err_base;
        run_count++;
        error_total += errs;
        if (errs == 0) begin
            $display("test %s: pass, %0d pixels compared", test_name, pix);
        end else begin
            fail_count++;
            $display("test %s: fail, %0d errors", test_name, errs);
        end
    endtask

endmodule

`default_nettype wire

/* dv/tb_fb_display.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer display testbench: clock, reset, RAM and palette loads,
// test sequence, watchdog and final report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_fb_display import fb_pkg::*; ();

    localparam int FRAME_LEN = (H_END - H_STA + 1) * (V_END - V_STA + 1);
    localparam int LOAD_LEN  = 2 * (FB_PIXELS + 2) + 3 * (16 + 2) + 8;  // fb x2, palette x3, reset
    // geometry 1 frame, each image test up to 2, plus margin
    localparam int RUN_LEN   = 8 * FRAME_LEN + LOAD_LEN + 1000;

    logic     clk_pix = 1'b0;
    logic     reset;
    logic     fb_we;
    fb_addr_t fb_waddr;
    cidx_t    fb_wdata;
    logic     clut_we;
    cidx_t    clut_widx;
    colr_t    clut_wcolr;
    sdl_pix_t sdl;
    logic     check_en;                 // compare enable for the checker
    cidx_t    fb_mirror [FB_PIXELS];    // what the framebuffer should hold
    colr_t    pal_mirror [16];
    int       tests_run;
    int       tests_failed;
    int       total_errors;

    always #50 clk_pix = ~clk_pix;  // 100 ns pixel clock

    fb_display_top dut (
        .clk_pix, .reset,
        .fb_we, .fb_waddr, .fb_wdata,
        .clut_we, .clut_widx, .clut_wcolr,
        .sdl
    );

    fb_checker chk (
        .clk_pix, .reset, .check_en, .sdl,
        .fb_mirror, .pal_mirror,
        .tests_run, .tests_failed, .total_errors
    );

    task automatic write_fb(input int addr, input cidx_t idx);
        @(negedge clk_pix);
        fb_we           = 1'b1;
        fb_waddr        = fb_addr_t'(addr);
        fb_wdata        = idx;
        fb_mirror[addr] = idx;
    endtask

    task automatic write_pal(input int idx, input colr_t c);
        @(negedge clk_pix);
        clut_we         = 1'b1;
        clut_widx       = cidx_t'(idx);
        clut_wcolr      = c;
        pal_mirror[idx] = c;
    endtask

    task automatic end_writes();
        @(negedge clk_pix);
        fb_we   = 1'b0;
        clut_we = 1'b0;
    endtask

    task automatic load_fb_gradient();
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                write_fb(y * FB_WIDTH + x, cidx_t'((x + y) % 16));  // diagonal bands
            end
        end
        end_writes();
    endtask

    task automatic load_fb_random();
        for (int a = 0; a < FB_PIXELS; a++) begin
            write_fb(a, cidx_t'($urandom));
        end
        end_writes();
    endtask

    task automatic load_pal_grey();
        for (int i = 0; i < 16; i++) begin
            write_pal(i, {cidx_t'(i), cidx_t'(i), cidx_t'(i)});
        end
        end_writes();
    endtask

    task automatic load_pal_random();
        for (int i = 0; i < 16; i++) begin
            write_pal(i, colr_t'($urandom));
        end
        end_writes();
    endtask

    // returns in the cycle the output shows a frame pulse
    task automatic wait_out_frame();
        do @(posedge clk_pix); while (sdl.pos.frame !== 1'b1);
    endtask

    // compare from one output frame pulse to the next
    task automatic check_next_frame();
        wait_out_frame();
        @(negedge clk_pix);
        check_en = 1'b1;
        wait_out_frame();
        @(negedge clk_pix);
        check_en = 1'b0;
        chk.end_test(1'b1);
    endtask

    initial begin
        void'($urandom(32'h49d));
        reset      = 1'b1;
        check_en   = 1'b0;
        fb_we      = 1'b0;
        fb_waddr   = '0;
        fb_wdata   = '0;
        clut_we    = 1'b0;
        clut_widx  = '0;
        clut_wcolr = '0;
        chk.begin_test("reset_state");
        repeat (8) @(negedge clk_pix);
        reset = 1'b0;
        wait_out_frame();
        @(negedge clk_pix);
        chk.end_test(1'b0);
        chk.begin_test("frame_geometry");
        wait_out_frame();  // second pulse closes a whole frame
        @(negedge clk_pix);
        chk.check_geometry();
        chk.end_test(1'b0);
        chk.begin_test("gradient");
        load_pal_grey();
        load_fb_gradient();
        check_next_frame();
        chk.begin_test("random_image");
        load_fb_random();
        load_pal_random();
        check_next_frame();
        chk.begin_test("palette_rewrite");
        load_pal_random();  // framebuffer kept
        check_next_frame();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && tests_run == 5) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (RUN_LEN) @(posedge clk_pix);
        $display("timeout: run did not finish within %0d cycles", RUN_LEN);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
common/fb_pkg.sv
src/display_timing.sv
framebuffer/fb_bram.sv
framebuffer/fb_reader.sv
src/clut.sv
src/pixel_out.sv
src/fb_display_top.sv
dv/fb_checker.sv
dv/tb_fb_display.sv

/* run_sim.sh */
#!/bin/sh
# build and run the framebuffer display testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fb_display \
    -Mdir obj_dir \
    -f sources.f

out=$(./obj_dir/Vtb_fb_display)
printf '%s\n' "$out"

# pass only when the testbench printed the pass line
if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
